// ==== flist.f ====
verilog/exe_op_pkg.sv
verilog/exe_ctl_pkg.sv
verilog/alu_shifter.sv
verilog/alu_core.sv
verilog/mul_iter.sv
verilog/exe_issue.sv
verilog/exe_execute.sv
verilog/exe_top.sv
tests/tb_exe_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the exe_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_exe_top -f flist.f \
    -o tb_exe_top > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_exe_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0

// ==== tests/tb_exe_top.sv ====
`timescale 1ns/10ps

module tb_exe_top;

    localparam int XLEN   = 64;
    localparam int HALF   = XLEN / 2;
    localparam int SW     = $clog2(XLEN);
    // rounds per test group
    localparam int N_ALU  = 10;
    localparam int N_WORD = 8;
    localparam int N_MUL  = 8;
    localparam int N_MIX  = 40;
    localparam int N_OPS  = 11 * N_ALU + 5 * N_WORD + 4 * N_MUL + N_MIX + 2;
    localparam longint WD_NS = longint'(N_OPS) * (XLEN + 20) * 40;

    typedef struct packed {
        logic [exe_op_pkg::OP_W-1:0] op;
        logic                        mul;
        logic [1:0]                  sel;
        logic [XLEN-1:0]             a;
        logic [XLEN-1:0]             b;
    } op_item_t;

    logic                        clk;
    logic                        rst_n;
    logic                        flush_i;
    logic                        up_req_i;
    logic [exe_op_pkg::OP_W-1:0] op_i;
    logic                        mul_i;
    logic [1:0]                  mul_sel_i;
    logic [XLEN-1:0]             src1_i;
    logic [XLEN-1:0]             src2_i;
    logic                        dn_ack_i;
    logic                        up_ack_o;
    logic                        dn_req_o;
    logic [XLEN-1:0]             res_o;
    logic                        less_o;
    logic                        zero_o;

    op_item_t    exp_q[$];
    logic [63:0] src_rng;
    logic [63:0] ack_rng;
    string       cur_test;
    int          errors;
    int          test_err0;
    int          n_sent;
    int          n_expected;
    int          n_done;
    int          ack_rises;
    int          n_tests;
    int          n_failed_tests;

    exe_top #(
        .XLEN (XLEN)
    ) u_exe_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush_i   (flush_i),
        .up_req_i  (up_req_i),
        .op_i      (op_i),
        .mul_i     (mul_i),
        .mul_sel_i (mul_sel_i),
        .src1_i    (src1_i),
        .src2_i    (src2_i),
        .dn_ack_i  (dn_ack_i),
        .up_ack_o  (up_ack_o),
        .dn_req_o  (dn_req_o),
        .res_o     (res_o),
        .less_o    (less_o),
        .zero_o    (zero_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    // roughly three in eight draws land on a corner value
    function automatic logic [XLEN-1:0] corner_mix(input logic [63:0] r);
        case (r[2:0])
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return {1'b1, {(XLEN-1){1'b0}}};
            default: return r[XLEN-1:0];
        endcase
    endfunction

    // opcode for the eleven ALU operations with bit 3 as the variant
    function automatic logic [exe_op_pkg::OP_W-1:0] alu_code(input int k);
        case (k)
            0:       return {2'b00, exe_op_pkg::FN_ADD};
            1:       return {2'b01, exe_op_pkg::FN_ADD};
            2:       return {2'b00, exe_op_pkg::FN_SLL};
            3:       return {2'b00, exe_op_pkg::FN_SLT};
            4:       return {2'b01, exe_op_pkg::FN_SLT};
            5:       return {2'b00, exe_op_pkg::FN_PASS2};
            6:       return {2'b00, exe_op_pkg::FN_XOR};
            7:       return {2'b00, exe_op_pkg::FN_SR};
            8:       return {2'b01, exe_op_pkg::FN_SR};
            9:       return {2'b00, exe_op_pkg::FN_OR};
            default: return {2'b00, exe_op_pkg::FN_AND};
        endcase
    endfunction

    // add, sub, sll, srl, sra in word mode
    function automatic logic [exe_op_pkg::OP_W-1:0] word_code(input int j);
        logic [exe_op_pkg::OP_W-1:0] c;
        case (j)
            0:       c = alu_code(0);
            1:       c = alu_code(1);
            2:       c = alu_code(2);
            3:       c = alu_code(7);
            default: c = alu_code(8);
        endcase
        c[exe_op_pkg::OP_WORD_BIT] = 1'b1;
        return c;
    endfunction

    function automatic string op_name(input op_item_t it);
        string s;
        if (it.mul) begin
            case (it.sel)
                2'd0:    s = "mul";
                2'd1:    s = "mulh";
                2'd2:    s = "mulhsu";
                default: s = "mulhu";
            endcase
            return s;
        end
        case (it.op[2:0])
            exe_op_pkg::FN_ADD:   s = it.op[exe_op_pkg::OP_VAR_BIT] ? "sub" : "add";
            exe_op_pkg::FN_SLL:   s = "sll";
            exe_op_pkg::FN_SLT:   s = it.op[exe_op_pkg::OP_VAR_BIT] ? "sltu" : "slt";
            exe_op_pkg::FN_PASS2: s = "pass2";
            exe_op_pkg::FN_XOR:   s = "xor";
            exe_op_pkg::FN_SR:    s = it.op[exe_op_pkg::OP_VAR_BIT] ? "sra" : "srl";
            exe_op_pkg::FN_OR:    s = "or";
            default:              s = "and";
        endcase
        if (it.op[exe_op_pkg::OP_WORD_BIT]) begin
            s = {s, "w"};
        end
        return s;
    endfunction

    // returns {result, less, zero}
    function automatic logic [XLEN+1:0] expected_result(input op_item_t it);
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [XLEN-1:0]   r;
        logic [XLEN-1:0]   sh_src;
        logic [XLEN:0]     ext;
        logic [2*XLEN-1:0] pa;
        logic [2*XLEN-1:0] pb;
        logic [2*XLEN-1:0] prod;
        logic [2:0]        fn;
        logic              word;
        logic              vbit;
        logic              sub;
        logic              less;
        int                sh;
        a = it.a;
        b = it.b;
        if (it.mul) begin
            // mulh and mulhsu take src1 as signed and only mulh takes src2 as signed
            pa   = (it.sel == 2'd1 || it.sel == 2'd2) ? {{XLEN{a[XLEN-1]}}, a}
                                                      : {{XLEN{1'b0}}, a};
            pb   = (it.sel == 2'd1) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
            prod = pa * pb;
            r    = (it.sel == 2'd0) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
            return {r, 2'b00};
        end
        fn   = it.op[2:0];
        word = it.op[exe_op_pkg::OP_WORD_BIT];
        vbit = it.op[exe_op_pkg::OP_VAR_BIT];
        sub  = (fn == exe_op_pkg::FN_ADD && vbit) || (fn == exe_op_pkg::FN_SLT);
        // exact signed sum one bit wider whose top bit is the signed less flag
        ext  = {a[XLEN-1], a} + (sub ? -{b[XLEN-1], b} : {b[XLEN-1], b});
        if (fn == exe_op_pkg::FN_SLT && vbit) begin
            less = (a < b);
        end else begin
            less = ext[XLEN];
        end
        sh = word ? int'(b[SW-2:0]) : int'(b[SW-1:0]);
        case (fn)
            exe_op_pkg::FN_SLL:   r = a << sh;
            exe_op_pkg::FN_SLT:   r = {{(XLEN-1){1'b0}}, less};
            exe_op_pkg::FN_PASS2: r = b;
            exe_op_pkg::FN_XOR:   r = a ^ b;
            exe_op_pkg::FN_SR: begin
                if (vbit) begin
                    sh_src = word ? {{HALF{a[HALF-1]}}, a[HALF-1:0]} : a;
                    r = $signed(sh_src) >>> sh;
                end else begin
                    sh_src = word ? {{HALF{1'b0}}, a[HALF-1:0]} : a;
                    r = sh_src >> sh;
                end
            end
            exe_op_pkg::FN_OR:    r = a | b;
            exe_op_pkg::FN_AND:   r = a & b;
            default:              r = ext[XLEN-1:0];
        endcase
        if (word) begin
            r = {{HALF{r[HALF-1]}}, r[HALF-1:0]};
        end
        return {r, less, ext[XLEN-1:0] == '0};
    endfunction

    task automatic make_item(input logic [exe_op_pkg::OP_W-1:0] op, input logic mul,
                             input logic [1:0] sel, output op_item_t it);
        logic shift;
        it.op   = op;
        it.mul  = mul;
        it.sel  = sel;
        src_rng = xorshift(src_rng);
        it.a    = corner_mix(src_rng);
        src_rng = xorshift(src_rng);
        shift   = !mul && (op[2:0] == exe_op_pkg::FN_SLL || op[2:0] == exe_op_pkg::FN_SR);
        if (shift) begin
            // shift amounts 0 and XLEN-1 as corners
            case (src_rng[2:0])
                3'd0:    it.b = '0;
                3'd1:    it.b = XLEN'(XLEN - 1);
                default: it.b = src_rng[XLEN-1:0];
            endcase
        end else begin
            it.b = corner_mix(src_rng);
        end
    endtask

    task automatic send_op(input op_item_t it, input logic expect_res, input logic flush_after);
        do @(negedge clk); while (up_ack_o);
        @(posedge clk);
        up_req_i  <= 1'b1;
        op_i      <= it.op;
        mul_i     <= it.mul;
        mul_sel_i <= it.sel;
        src1_i    <= it.a;
        src2_i    <= it.b;
        n_sent++;
        if (expect_res) begin
            exp_q.push_back(it);
            n_expected++;
        end
        do @(negedge clk); while (!up_ack_o);
        @(posedge clk);
        up_req_i <= 1'b0;
        if (flush_after) begin
            // flush lands three cycles after up_ack_o rose
            repeat (2) @(posedge clk);
            flush_i <= 1'b1;
            @(posedge clk);
            flush_i <= 1'b0;
        end
    endtask

    task automatic drain();
        while (n_done < n_expected) @(negedge clk);
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task automatic finish_test();
        int n;
        drain();
        n = errors - test_err0;
        n_tests++;
        if (n == 0) begin
            $display("test %s ok", cur_test);
        end else begin
            $display("test %s failed with %0d errors", cur_test, n);
            n_failed_tests++;
        end
    endtask

    // sink side with a random ack delay that compares in order
    initial begin : sink
        op_item_t        it;
        logic [XLEN+1:0] want;
        int              delay;
        string           nm;
        logic            popped;
        wait (rst_n === 1'b1);
        forever begin
            do @(negedge clk); while (!dn_req_o);
            popped = (exp_q.size() != 0);
            assert (popped) else begin
                $display("result delivered in test %s with no request pending", cur_test);
                errors++;
            end
            if (popped) begin
                it   = exp_q.pop_front();
                want = expected_result(it);
                nm   = op_name(it);
                assert (res_o === want[XLEN+1:2]) else begin
                    $display("FAILED %s %s res expected %h actual %h",
                             cur_test, nm, want[XLEN+1:2], res_o);
                    errors++;
                end
                assert (less_o === want[1]) else begin
                    $display("FAILED %s %s less expected %b actual %b",
                             cur_test, nm, want[1], less_o);
                    errors++;
                end
                assert (zero_o === want[0]) else begin
                    $display("FAILED %s %s zero expected %b actual %b",
                             cur_test, nm, want[0], zero_o);
                    errors++;
                end
            end
            ack_rng = xorshift(ack_rng);
            delay   = int'(ack_rng % 64'd6);
            repeat (delay) @(posedge clk);
            @(posedge clk);
            dn_ack_i <= 1'b1;
            do @(negedge clk); while (dn_req_o);
            @(posedge clk);
            dn_ack_i <= 1'b0;
            if (popped) begin
                n_done++;
            end
        end
    end

    initial begin : ack_monitor
        logic prev;
        prev = 1'b0;
        forever begin
            @(negedge clk);
            if (up_ack_o && !prev) begin
                ack_rises++;
            end
            prev = up_ack_o;
        end
    end

    initial begin : watchdog
        #(WD_NS);
        $display("timeout after %0d ns, the DUT stopped responding", WD_NS);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        op_item_t it;
        int       r;
        int       j;
        int       k;
        rst_n          = 1'b0;
        flush_i        = 1'b0;
        up_req_i       = 1'b0;
        op_i           = '0;
        mul_i          = 1'b0;
        mul_sel_i      = 2'd0;
        src1_i         = '0;
        src2_i         = '0;
        dn_ack_i       = 1'b0;
        src_rng        = 64'd20709;
        ack_rng        = xorshift(64'd20709);
        errors         = 0;
        n_sent         = 0;
        n_expected     = 0;
        n_done         = 0;
        ack_rises      = 0;
        n_tests        = 0;
        n_failed_tests = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset");
        @(negedge clk);
        assert (!up_ack_o && !dn_req_o) else begin
            $display("up_ack_o or dn_req_o high after reset with no request");
            errors++;
        end
        finish_test();

        start_test("alu64");
        for (r = 0; r < N_ALU; r++) begin
            for (j = 0; j < 11; j++) begin
                make_item(alu_code(j), 1'b0, 2'd0, it);
                send_op(it, 1'b1, 1'b0);
            end
        end
        finish_test();

        start_test("word");
        for (r = 0; r < N_WORD; r++) begin
            for (j = 0; j < 5; j++) begin
                make_item(word_code(j), 1'b0, 2'd0, it);
                send_op(it, 1'b1, 1'b0);
            end
        end
        finish_test();

        start_test("mul");
        for (r = 0; r < N_MUL; r++) begin
            for (j = 0; j < 4; j++) begin
                make_item('0, 1'b1, 2'(j), it);
                send_op(it, 1'b1, 1'b0);
            end
        end
        finish_test();

        // mixed ALU and multiply traffic against random sink delays
        start_test("backpressure");
        for (r = 0; r < N_MIX; r++) begin
            src_rng = xorshift(src_rng);
            k = int'(src_rng % 64'd15);
            if (k >= 11) begin
                make_item('0, 1'b1, 2'(k - 11), it);
            end else begin
                make_item(alu_code(k), 1'b0, 2'd0, it);
            end
            send_op(it, 1'b1, 1'b0);
        end
        drain();
        assert (ack_rises == n_sent) else begin
            $display("up_ack_o rose %0d times for %0d requests", ack_rises, n_sent);
            errors++;
        end
        finish_test();

        start_test("flush");
        drain();
        make_item('0, 1'b1, 2'd0, it);
        send_op(it, 1'b0, 1'b1);
        make_item(alu_code(0), 1'b0, 2'd0, it);
        send_op(it, 1'b1, 1'b0);
        drain();
        // a cancelled multiply must stay silent
        repeat (XLEN + 10) @(negedge clk);
        finish_test();

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 n_tests, n_failed_tests, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verilog/alu_core.sv ====
`timescale 1ns/10ps

module alu_core #(
    parameter int XLEN = 64
) (
    input  exe_op_pkg::alu_op_e alu_op_i,
    input  logic                word_i,
    input  logic [XLEN-1:0]     src1_i,
    input  logic [XLEN-1:0]     src2_i,
    output logic [XLEN-1:0]     res_o,
    output logic                less_o,
    output logic                zero_o
);

    localparam int SW   = $clog2(XLEN);
    localparam int HALF = XLEN / 2;

    logic            sub_en;
    logic [XLEN-1:0] b_inv;
    logic [XLEN:0]   sum_full;
    logic [XLEN-1:0] sum;
    logic            carry;
    logic            overflow;
    logic            right;
    logic            arith;
    logic [XLEN-1:0] shift;
    logic [XLEN-1:0] alu_out;

    // compares reuse the subtractor
    assign sub_en = (alu_op_i == exe_op_pkg::alu_sub) || (alu_op_i == exe_op_pkg::alu_slt)
                 || (alu_op_i == exe_op_pkg::alu_sltu);
    assign b_inv    = src2_i ^ {XLEN{sub_en}};
    assign sum_full = {1'b0, src1_i} + {1'b0, b_inv} + {{XLEN{1'b0}}, sub_en};
    assign sum      = sum_full[XLEN-1:0];
    assign carry    = sum_full[XLEN];
    assign overflow = (src1_i[XLEN-1] == b_inv[XLEN-1]) && (sum[XLEN-1] != src1_i[XLEN-1]);

    // borrow for unsigned, sign vs overflow for signed
    assign less_o = (alu_op_i == exe_op_pkg::alu_sltu) ? (carry ^ sub_en)
                                                       : (sum[XLEN-1] ^ overflow);
    assign zero_o = ~(|sum);

    assign right = (alu_op_i == exe_op_pkg::alu_srl) || (alu_op_i == exe_op_pkg::alu_sra);
    assign arith = (alu_op_i == exe_op_pkg::alu_sra);

    alu_shifter #(
        .XLEN (XLEN)
    ) u_alu_shifter (
        .src_i   (src1_i),
        .amt_i   (src2_i[SW-1:0]),
        .right_i (right),
        .arith_i (arith),
        .word_i  (word_i),
        .shift_o (shift)
    );

    always_comb begin
        case (alu_op_i)
            exe_op_pkg::alu_sll,
            exe_op_pkg::alu_srl,
            exe_op_pkg::alu_sra:   alu_out = shift;
            exe_op_pkg::alu_slt,
            exe_op_pkg::alu_sltu:  alu_out = {{(XLEN-1){1'b0}}, less_o};
            exe_op_pkg::alu_pass2: alu_out = src2_i;
            exe_op_pkg::alu_xor:   alu_out = src1_i ^ src2_i;
            exe_op_pkg::alu_or:    alu_out = src1_i | src2_i;
            exe_op_pkg::alu_and:   alu_out = src1_i & src2_i;
            default:               alu_out = sum;
        endcase
    end

    // word results are sign extended from the low half
    assign res_o = word_i ? {{HALF{alu_out[HALF-1]}}, alu_out[HALF-1:0]} : alu_out;

endmodule

// ==== verilog/alu_shifter.sv ====
`timescale 1ns/10ps

module alu_shifter #(
    parameter int XLEN = 64
) (
    input  logic [XLEN-1:0]         src_i,
    input  logic [$clog2(XLEN)-1:0] amt_i,
    input  logic                    right_i,
    input  logic                    arith_i,
    input  logic                    word_i,
    output logic [XLEN-1:0]         shift_o
);

    localparam int SW   = $clog2(XLEN);
    localparam int HALF = XLEN / 2;

    logic [SW-1:0]   amt;
    logic [XLEN-1:0] src_w;
    logic [XLEN-1:0] src_rev;
    logic [XLEN-1:0] shr_in;
    logic [XLEN-1:0] shr_res;
    logic [XLEN-1:0] res_rev;
    logic [XLEN-1:0] ones;
    logic [XLEN-1:0] fill;
    logic            sign;

    // word mode works on the low half only
    assign amt   = word_i ? {1'b0, amt_i[SW-2:0]} : amt_i;
    assign src_w = word_i ? {{HALF{1'b0}}, src_i[HALF-1:0]} : src_i;
    assign sign  = word_i ? src_i[HALF-1] : src_i[XLEN-1];
    assign ones  = word_i ? {{HALF{1'b0}}, {HALF{1'b1}}} : {XLEN{1'b1}};

    for (genvar i = 0; i < XLEN; i++) begin : g_rev
        assign src_rev[i] = src_w[XLEN-1-i];
        assign res_rev[i] = shr_res[XLEN-1-i];
    end

    // left shift runs reversed through the right shifter
    assign shr_in  = right_i ? src_w : src_rev;
    assign shr_res = shr_in >> amt;

    // bits vacated at the top of the active field
    assign fill = ~(ones >> amt);

    assign shift_o = right_i ? (shr_res | (fill & {XLEN{sign & arith_i}})) : res_rev;

endmodule

// ==== verilog/exe_ctl_pkg.sv ====
package exe_ctl_pkg;

    // four-phase port, seen from the side that raises req or ack
    typedef enum logic [1:0] {
        hs_idle,
        hs_req_high,
        hs_wait_release
    } hs_state_e;

    typedef enum logic [1:0] {
        ms_idle,
        ms_busy,
        ms_done
    } mul_state_e;

endpackage

// ==== verilog/exe_execute.sv ====
`timescale 1ns/10ps

module exe_execute #(
    parameter int XLEN = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush_i,
    input  logic                  iss_req_i,
    input  exe_op_pkg::alu_op_e   iss_alu_op_i,
    input  logic                  iss_mul_i,
    input  exe_op_pkg::mul_type_e iss_mul_type_i,
    input  logic                  iss_word_i,
    input  logic [XLEN-1:0]       iss_src1_i,
    input  logic [XLEN-1:0]       iss_src2_i,
    input  logic                  dn_ack_i,
    output logic                  iss_ack_o,
    output logic                  dn_req_o,
    output logic [XLEN-1:0]       res_o,
    output logic                  less_o,
    output logic                  zero_o
);

    localparam int HALF = XLEN / 2;

    exe_ctl_pkg::hs_state_e dn_state_q;
    logic                   mul_pend_q;
    logic                   accept;
    logic                   mul_start;
    logic [XLEN-1:0]        alu_res;
    logic                   alu_less;
    logic                   alu_zero;
    logic                   mul_done;
    logic [XLEN-1:0]        mul_prod;
    logic [XLEN-1:0]        mul_res;

    // new item only with a free result register and no multiply running
    assign accept = iss_req_i && !iss_ack_o && !mul_pend_q
                 && (dn_state_q == exe_ctl_pkg::hs_idle);
    assign mul_start = accept && iss_mul_i;
    assign mul_res   = iss_word_i ? {{HALF{mul_prod[HALF-1]}}, mul_prod[HALF-1:0]} : mul_prod;
    assign dn_req_o  = (dn_state_q == exe_ctl_pkg::hs_req_high);

    alu_core #(
        .XLEN (XLEN)
    ) u_alu_core (
        .alu_op_i (iss_alu_op_i),
        .word_i   (iss_word_i),
        .src1_i   (iss_src1_i),
        .src2_i   (iss_src2_i),
        .res_o    (alu_res),
        .less_o   (alu_less),
        .zero_o   (alu_zero)
    );

    mul_iter #(
        .XLEN (XLEN)
    ) u_mul_iter (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (mul_start),
        .flush_i    (flush_i),
        .mul_type_i (iss_mul_type_i),
        .src1_i     (iss_src1_i),
        .src2_i     (iss_src2_i),
        .done_o     (mul_done),
        .prod_o     (mul_prod)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dn_state_q <= exe_ctl_pkg::hs_idle;
            mul_pend_q <= 1'b0;
            iss_ack_o  <= 1'b0;
        end else begin
            if (accept && !iss_mul_i) begin
                iss_ack_o  <= 1'b1;
                dn_state_q <= exe_ctl_pkg::hs_req_high;
            end else if (mul_start) begin
                mul_pend_q <= 1'b1;
            end else if (mul_pend_q && mul_done) begin
                mul_pend_q <= 1'b0;
                iss_ack_o  <= 1'b1;
                dn_state_q <= exe_ctl_pkg::hs_req_high;
            end else if (mul_pend_q && flush_i) begin
                // cancelled multiply, item retired with no result
                mul_pend_q <= 1'b0;
                iss_ack_o  <= 1'b1;
            end else if (!iss_req_i) begin
                iss_ack_o <= 1'b0;
            end
            if (dn_state_q == exe_ctl_pkg::hs_req_high && dn_ack_i) begin
                dn_state_q <= exe_ctl_pkg::hs_wait_release;
            end else if (dn_state_q == exe_ctl_pkg::hs_wait_release && !dn_ack_i) begin
                dn_state_q <= exe_ctl_pkg::hs_idle;
            end
        end
    end

    // result register and flags
    always_ff @(posedge clk) begin
        if (accept && !iss_mul_i) begin
            res_o  <= alu_res;
            less_o <= alu_less;
            zero_o <= alu_zero;
        end else if (mul_pend_q && mul_done) begin
            res_o  <= mul_res;
            less_o <= 1'b0;
            zero_o <= 1'b0;
        end
    end

endmodule

// ==== verilog/exe_issue.sv ====
`timescale 1ns/10ps

module exe_issue #(
    parameter int XLEN = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          up_req_i,
    input  logic [exe_op_pkg::OP_W-1:0]   op_i,
    input  logic                          mul_i,
    input  logic [1:0]                    mul_sel_i,
    input  logic [XLEN-1:0]               src1_i,
    input  logic [XLEN-1:0]               src2_i,
    input  logic                          iss_ack_i,
    output logic                          up_ack_o,
    output logic                          iss_req_o,
    output exe_op_pkg::alu_op_e           iss_alu_op_o,
    output logic                          iss_mul_o,
    output exe_op_pkg::mul_type_e         iss_mul_type_o,
    output logic                          iss_word_o,
    output logic [XLEN-1:0]               iss_src1_o,
    output logic [XLEN-1:0]               iss_src2_o
);

    exe_ctl_pkg::hs_state_e state_q;
    exe_op_pkg::alu_op_e    op_dec;
    logic                   capture;
    logic                   variant;

    // only take a new item once the stage has drained
    assign capture = up_req_i && !up_ack_o && (state_q == exe_ctl_pkg::hs_idle);
    assign variant = op_i[exe_op_pkg::OP_VAR_BIT];
    assign iss_req_o = (state_q == exe_ctl_pkg::hs_req_high);

    always_comb begin
        case (op_i[2:0])
            exe_op_pkg::FN_ADD:   op_dec = variant ? exe_op_pkg::alu_sub : exe_op_pkg::alu_add;
            exe_op_pkg::FN_SLL:   op_dec = exe_op_pkg::alu_sll;
            exe_op_pkg::FN_SLT:   op_dec = variant ? exe_op_pkg::alu_sltu : exe_op_pkg::alu_slt;
            exe_op_pkg::FN_PASS2: op_dec = exe_op_pkg::alu_pass2;
            exe_op_pkg::FN_XOR:   op_dec = exe_op_pkg::alu_xor;
            exe_op_pkg::FN_SR:    op_dec = variant ? exe_op_pkg::alu_sra : exe_op_pkg::alu_srl;
            exe_op_pkg::FN_OR:    op_dec = exe_op_pkg::alu_or;
            default:              op_dec = exe_op_pkg::alu_and;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= exe_ctl_pkg::hs_idle;
            up_ack_o <= 1'b0;
        end else begin
            if (capture) begin
                up_ack_o <= 1'b1;
            end else if (!up_req_i) begin
                up_ack_o <= 1'b0;
            end
            case (state_q)
                exe_ctl_pkg::hs_idle: begin
                    if (capture) begin
                        state_q <= exe_ctl_pkg::hs_req_high;
                    end
                end
                exe_ctl_pkg::hs_req_high: begin
                    if (iss_ack_i) begin
                        state_q <= exe_ctl_pkg::hs_wait_release;
                    end
                end
                default: begin
                    if (!iss_ack_i) begin
                        state_q <= exe_ctl_pkg::hs_idle;
                    end
                end
            endcase
        end
    end

    // held item
    always_ff @(posedge clk) begin
        if (capture) begin
            iss_alu_op_o   <= op_dec;
            iss_mul_o      <= mul_i;
            iss_mul_type_o <= exe_op_pkg::mul_type_e'(mul_sel_i);
            iss_word_o     <= op_i[exe_op_pkg::OP_WORD_BIT];
            iss_src1_o     <= src1_i;
            iss_src2_o     <= src2_i;
        end
    end

endmodule

// ==== verilog/exe_op_pkg.sv ====
package exe_op_pkg;

    // external opcode field
    localparam int OP_W        = 5;
    localparam int OP_WORD_BIT = 4;
    localparam int OP_VAR_BIT  = 3;

    // function select in op[2:0]
    localparam logic [2:0] FN_ADD   = 3'd0;
    localparam logic [2:0] FN_SLL   = 3'd1;
    localparam logic [2:0] FN_SLT   = 3'd2;
    localparam logic [2:0] FN_PASS2 = 3'd3;
    localparam logic [2:0] FN_XOR   = 3'd4;
    localparam logic [2:0] FN_SR    = 3'd5;
    localparam logic [2:0] FN_OR    = 3'd6;
    localparam logic [2:0] FN_AND   = 3'd7;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_pass2,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    // same order as the funct3 of the multiply group
    typedef enum logic [1:0] {mt_mul, mt_mulh, mt_mulhsu, mt_mulhu} mul_type_e;

endpackage

// ==== verilog/exe_top.sv ====
`timescale 1ns/10ps

module exe_top #(
    parameter int XLEN = 64
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush_i,
    input  logic                        up_req_i,
    input  logic [exe_op_pkg::OP_W-1:0] op_i,
    input  logic                        mul_i,
    input  logic [1:0]                  mul_sel_i,
    input  logic [XLEN-1:0]             src1_i,
    input  logic [XLEN-1:0]             src2_i,
    input  logic                        dn_ack_i,
    output logic                        up_ack_o,
    output logic                        dn_req_o,
    output logic [XLEN-1:0]             res_o,
    output logic                        less_o,
    output logic                        zero_o
);

    // issue to execute
    logic                  iss_req;
    logic                  iss_ack;
    exe_op_pkg::alu_op_e   iss_alu_op;
    logic                  iss_mul;
    exe_op_pkg::mul_type_e iss_mul_type;
    logic                  iss_word;
    logic [XLEN-1:0]       iss_src1;
    logic [XLEN-1:0]       iss_src2;

    exe_issue #(
        .XLEN (XLEN)
    ) u_exe_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .up_req_i       (up_req_i),
        .op_i           (op_i),
        .mul_i          (mul_i),
        .mul_sel_i      (mul_sel_i),
        .src1_i         (src1_i),
        .src2_i         (src2_i),
        .iss_ack_i      (iss_ack),
        .up_ack_o       (up_ack_o),
        .iss_req_o      (iss_req),
        .iss_alu_op_o   (iss_alu_op),
        .iss_mul_o      (iss_mul),
        .iss_mul_type_o (iss_mul_type),
        .iss_word_o     (iss_word),
        .iss_src1_o     (iss_src1),
        .iss_src2_o     (iss_src2)
    );

    exe_execute #(
        .XLEN (XLEN)
    ) u_exe_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_i        (flush_i),
        .iss_req_i      (iss_req),
        .iss_alu_op_i   (iss_alu_op),
        .iss_mul_i      (iss_mul),
        .iss_mul_type_i (iss_mul_type),
        .iss_word_i     (iss_word),
        .iss_src1_i     (iss_src1),
        .iss_src2_i     (iss_src2),
        .dn_ack_i       (dn_ack_i),
        .iss_ack_o      (iss_ack),
        .dn_req_o       (dn_req_o),
        .res_o          (res_o),
        .less_o         (less_o),
        .zero_o         (zero_o)
    );

endmodule

// ==== verilog/mul_iter.sv ====
`timescale 1ns/10ps

module mul_iter #(
    parameter int XLEN = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  logic                  flush_i,
    input  exe_op_pkg::mul_type_e mul_type_i,
    input  logic [XLEN-1:0]       src1_i,
    input  logic [XLEN-1:0]       src2_i,
    output logic                  done_o,
    output logic [XLEN-1:0]       prod_o
);

    localparam int CW = $clog2(XLEN);

    exe_ctl_pkg::mul_state_e state_q;
    logic [CW-1:0]           cnt_q;
    logic [2*XLEN-1:0]       mcand_q;
    logic [XLEN-1:0]         mplier_q;
    logic [2*XLEN-1:0]       acc_q;
    logic                    neg_q;
    logic                    lo_sel_q;
    logic                    a_neg;
    logic                    b_neg;
    logic [XLEN-1:0]         a_mag;
    logic [XLEN-1:0]         b_mag;
    logic [2*XLEN-1:0]       prod_full;

    // operand signs as the type defines them
    assign a_neg = src1_i[XLEN-1] && ((mul_type_i == exe_op_pkg::mt_mulh)
                                   || (mul_type_i == exe_op_pkg::mt_mulhsu));
    assign b_neg = src2_i[XLEN-1] && (mul_type_i == exe_op_pkg::mt_mulh);
    assign a_mag = a_neg ? -src1_i : src1_i;
    assign b_mag = b_neg ? -src2_i : src2_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= exe_ctl_pkg::ms_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                exe_ctl_pkg::ms_idle: begin
                    if (start_i) begin
                        state_q <= exe_ctl_pkg::ms_busy;
                        cnt_q   <= '0;
                    end
                end
                exe_ctl_pkg::ms_busy: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (flush_i) begin
                        state_q <= exe_ctl_pkg::ms_idle;
                    end else if (cnt_q == CW'(XLEN - 1)) begin
                        state_q <= exe_ctl_pkg::ms_done;
                    end
                end
                default: state_q <= exe_ctl_pkg::ms_idle;
            endcase
        end
    end

    // shift-add datapath over magnitudes
    always_ff @(posedge clk) begin
        if (state_q == exe_ctl_pkg::ms_idle && start_i) begin
            mcand_q  <= {{XLEN{1'b0}}, a_mag};
            mplier_q <= b_mag;
            acc_q    <= '0;
            neg_q    <= a_neg ^ b_neg;
            lo_sel_q <= (mul_type_i == exe_op_pkg::mt_mul);
        end else if (state_q == exe_ctl_pkg::ms_busy) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign prod_full = neg_q ? -acc_q : acc_q;
    assign prod_o    = lo_sel_q ? prod_full[XLEN-1:0] : prod_full[2*XLEN-1:XLEN];
    assign done_o    = (state_q == exe_ctl_pkg::ms_done);

endmodule
